//--- common/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instruction queue geometry
`define QUEUE_DEPTH 16
`define QPTR_W      4

// icache line shape
`define LINE_WORDS  8
`define WORD_W      32

`endif

//--- common/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'h00,
        OP_REGIMM   = 6'h01,
        OP_J        = 6'h02,
        OP_JAL      = 6'h03,
        OP_BEQ      = 6'h04,
        OP_BNE      = 6'h05,
        OP_BLEZ     = 6'h06,
        OP_BGTZ     = 6'h07,
        OP_COP0     = 6'h10,
        OP_SPECIAL2 = 6'h1c,
        OP_LB       = 6'h20,
        OP_LH       = 6'h21,
        OP_LWL      = 6'h22,
        OP_LW       = 6'h23,
        OP_LBU      = 6'h24,
        OP_LHU      = 6'h25,
        OP_LWR      = 6'h26
    } opcode_t;

    typedef enum logic [5:0] {
        FN_MUL   = 6'h02,
        FN_JR    = 6'h08,
        FN_JALR  = 6'h09,
        FN_MFHI  = 6'h10,
        FN_MFLO  = 6'h12,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a,
        FN_DIVU  = 6'h1b
    } funct_t;

    function automatic opcode_t op_of(inst_t inst);
        return opcode_t'(inst[31:26]);
    endfunction

    function automatic funct_t fn_of(inst_t inst);
        return funct_t'(inst[5:0]);
    endfunction

    function automatic reg_idx_t rs_of(inst_t inst);
        return inst[25:21];
    endfunction

    function automatic reg_idx_t rt_of(inst_t inst);
        return inst[20:16];
    endfunction

    function automatic reg_idx_t rd_of(inst_t inst);
        return inst[15:11];
    endfunction

    // mfhi/mflo with rs, rt and sa all zero
    function automatic logic is_mfhilo(inst_t inst);
        return op_of(inst) == OP_SPECIAL && fn_of(inst) inside {FN_MFHI, FN_MFLO}
            && inst[25:16] == 10'd0 && inst[10:6] == 5'd0;
    endfunction

    function automatic logic is_branch(inst_t inst);
        case (op_of(inst))
            OP_BEQ, OP_BNE, OP_J, OP_JAL: return 1'b1;
            OP_BLEZ, OP_BGTZ: return rt_of(inst) == 5'd0;
            // bltz, bgez, bltzal, bgezal
            OP_REGIMM: return rt_of(inst) inside {5'h00, 5'h01, 5'h10, 5'h11};
            OP_SPECIAL: begin
                return (fn_of(inst) == FN_JR && inst[20:6] == 15'd0)
                    || (fn_of(inst) == FN_JALR && rt_of(inst) == 5'd0 && inst[10:6] == 5'd0);
            end
            default: return 1'b0;
        endcase
    endfunction

    // results that are late: loads, mfc0, mfhi/mflo
    function automatic logic is_load_type(inst_t inst);
        case (op_of(inst))
            OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR: return 1'b1;
            OP_COP0: return rs_of(inst) == 5'd0 && inst[10:3] == 8'd0;
            OP_SPECIAL: return is_mfhilo(inst);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_muldiv(inst_t inst);
        case (op_of(inst))
            OP_SPECIAL2: return fn_of(inst) == FN_MUL && inst[10:6] == 5'd0;
            OP_SPECIAL: begin
                return fn_of(inst) inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU}
                    && inst[15:6] == 10'd0;
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic reg_idx_t dest_reg(inst_t inst);
        return is_mfhilo(inst) ? rd_of(inst) : rt_of(inst);
    endfunction

    // j/jal carry a target there, cop0 moves use rs as a sub-opcode
    function automatic logic reads_rs(inst_t inst);
        return !(op_of(inst) inside {OP_J, OP_JAL, OP_COP0});
    endfunction

    function automatic logic reads_rt(inst_t inst);
        case (op_of(inst))
            OP_SPECIAL, OP_SPECIAL2, OP_BEQ, OP_BNE, OP_LWL, OP_LWR: return 1'b1;
            // mtc0
            OP_COP0: return rs_of(inst) == 5'd4;
            // stores sit at 0x28..0x2f
            default: return inst[31:29] == 3'b101;
        endcase
    endfunction

endpackage

//--- common/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        WAIT_PREIF   = 2'd0,
        RECV_INST    = 2'd1,
        RECV_NO_INST = 2'd2,
        CLEAR_ALL    = 2'd3
    } fetch_state_t;

    typedef logic [`QPTR_W-1:0] qptr_t;

    // one queue slot, instruction word in the upper half
    typedef struct packed {
        isa_pkg::inst_t     inst;
        logic [`WORD_W-1:0] pc;
    } queue_entry_t;

endpackage

//--- fetch/fetch_ctrl.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               to_fs_valid,
    input  logic               no_inst,
    input  logic [`WORD_W-1:0] fetch_pc,
    input  logic               has_room,
    input  logic               cache_data_ok,
    input  logic [3:0]         cache_data_num,
    output logic               fs_allowin,
    output logic [5:0]         fs_to_preif_offset,
    output logic               in_clear_all,
    output logic               wr_line,
    output logic               wr_pair_zero,
    output logic [`WORD_W-1:0] wr_pc,
    output logic [3:0]         wr_count
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         req_take;

    assign fs_allowin   = (state == WAIT_PREIF) && has_room;
    assign req_take     = to_fs_valid && fs_allowin;
    assign in_clear_all = (state == CLEAR_ALL);

    always_comb begin
        state_next = state;
        case (state)
            WAIT_PREIF: begin
                if (req_take) begin
                    state_next = no_inst ? RECV_NO_INST : RECV_INST;
                end
            end
            RECV_INST: begin
                if (cache_data_ok) begin
                    state_next = WAIT_PREIF;
                end else if (flush) begin
                    state_next = CLEAR_ALL;
                end
            end
            RECV_NO_INST: begin
                state_next = WAIT_PREIF;
            end
            // line still in flight, swallow it
            CLEAR_ALL: begin
                if (cache_data_ok) begin
                    state_next = WAIT_PREIF;
                end
            end
            default: begin
                state_next = WAIT_PREIF;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WAIT_PREIF;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            wr_pc <= fetch_pc;
        end
    end

    // bytes consumed by the last line
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_to_preif_offset <= 6'd4;
        end else if (wr_line) begin
            fs_to_preif_offset <= {cache_data_num, 2'b00};
        end
    end

    assign wr_line      = (state == RECV_INST) && cache_data_ok && !flush;
    assign wr_pair_zero = (state == RECV_NO_INST) && !flush;
    assign wr_count     = wr_pair_zero ? 4'd2 : cache_data_num;

    // the icache only answers a request that was taken earlier
    a_no_stray_data: assert property (@(posedge clk) disable iff (reset)
        state == WAIT_PREIF |-> !cache_data_ok);

endmodule

//--- fetch/inst_queue.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module inst_queue (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           wr_line,
    input  logic                           wr_pair_zero,
    input  logic [`WORD_W-1:0]             wr_pc,
    input  logic [3:0]                     wr_count,
    input  logic [`LINE_WORDS*`WORD_W-1:0] line_data,
    input  logic                           issue,
    input  logic                           issue_two,
    output fetch_pkg::queue_entry_t        e0,
    output fetch_pkg::queue_entry_t        e1,
    output logic                           has_room,
    output logic                           has_pair
);
    import fetch_pkg::*;

    queue_entry_t mem [`QUEUE_DEPTH];
    qptr_t        head;
    qptr_t        tail;
    qptr_t        used;

    assign used = tail - head;

    // a whole line must fit without the tail catching the head
    assign has_room = used <= qptr_t'(`QUEUE_DEPTH - 1 - `LINE_WORDS);
    assign has_pair = used >= qptr_t'(2);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (wr_line || wr_pair_zero) begin
                tail <= tail + qptr_t'(wr_count);
            end
            if (issue) begin
                head <= head + (issue_two ? qptr_t'(2) : qptr_t'(1));
            end
        end
    end

    // full line always stored, only wr_count words count as queued
    always_ff @(posedge clk) begin
        for (int k = 0; k < `LINE_WORDS; k++) begin
            if (wr_line || (wr_pair_zero && k < 2)) begin
                mem[tail + qptr_t'(k)].inst <= wr_line ? line_data[k*`WORD_W +: `WORD_W] : '0;
                mem[tail + qptr_t'(k)].pc   <= wr_pc + `WORD_W'(4 * k);
            end
        end
    end

    assign e0 = mem[head];
    assign e1 = mem[head + qptr_t'(1)];

    // requests are only taken with room, and nothing else fills the ring meanwhile
    a_write_fits: assert property (@(posedge clk) disable iff (reset)
        (wr_line || wr_pair_zero) |-> has_room);

endmodule

//--- verilog/issue_pair.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module issue_pair (
    input  fetch_pkg::queue_entry_t e0,
    input  fetch_pkg::queue_entry_t e1,
    input  logic                    has_pair,
    input  logic                    flush,
    input  logic                    issuing_state_clear,
    input  logic                    ds_allowin,
    output logic                    fs_to_ds_valid,
    output isa_pkg::inst_t          inst1,
    output logic [`WORD_W-1:0]      pc1,
    output isa_pkg::inst_t          inst2,
    output logic [`WORD_W-1:0]      pc2,
    output logic                    inst2_valid,
    output logic                    issue,
    output logic                    issue_two
);
    import isa_pkg::*;

    inst_t    i1;
    inst_t    i2;
    reg_idx_t dest1;
    logic     rs_hit;
    logic     rt_hit;
    logic     load_dep;
    logic     muldiv_pair;
    logic     hold_inst2;

    assign i1 = e0.inst;
    assign i2 = e1.inst;

    assign fs_to_ds_valid = has_pair && !issuing_state_clear && !flush;

    // younger one needs a value the older load type returns too late
    assign dest1    = dest_reg(i1);
    assign rs_hit   = reads_rs(i2) && rs_of(i2) == dest1;
    assign rt_hit   = reads_rt(i2) && rt_of(i2) == dest1;
    assign load_dep = is_load_type(i1) && dest1 != 5'd0 && (rs_hit || rt_hit);

    // only one hi/lo unit
    assign muldiv_pair = is_muldiv(i1) && is_muldiv(i2);

    // a younger branch waits so it leaves together with its delay slot
    assign hold_inst2 = is_branch(i2) || load_dep || muldiv_pair;

    assign inst2_valid = !hold_inst2;

    assign inst1 = i1;
    assign pc1   = e0.pc;
    assign inst2 = i2 & {$bits(inst_t){inst2_valid}};
    assign pc2   = e1.pc;

    assign issue     = fs_to_ds_valid && ds_allowin;
    assign issue_two = issue && inst2_valid;

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           to_fs_valid,
    input  logic [`WORD_W-1:0]             fetch_pc,
    input  logic                           no_inst,
    input  logic                           cache_data_ok,
    input  logic [3:0]                     cache_data_num,
    input  logic [`LINE_WORDS*`WORD_W-1:0] cache_rdata,
    input  logic                           ds_allowin,
    input  logic                           flush,
    output logic                           fs_allowin,
    output logic [5:0]                     fs_to_preif_offset,
    output logic                           fs_to_ds_valid,
    output isa_pkg::inst_t                 inst1,
    output logic [`WORD_W-1:0]             pc1,
    output isa_pkg::inst_t                 inst2,
    output logic [`WORD_W-1:0]             pc2,
    output logic                           inst2_valid
);
    import fetch_pkg::*;

    logic               has_room;
    logic               has_pair;
    logic               in_clear_all;
    logic               wr_line;
    logic               wr_pair_zero;
    logic [`WORD_W-1:0] wr_pc;
    logic [3:0]         wr_count;
    logic               issue;
    logic               issue_two;
    queue_entry_t       e0;
    queue_entry_t       e1;

    fetch_ctrl u_ctrl (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .to_fs_valid        (to_fs_valid),
        .no_inst            (no_inst),
        .fetch_pc           (fetch_pc),
        .has_room           (has_room),
        .cache_data_ok      (cache_data_ok),
        .cache_data_num     (cache_data_num),
        .fs_allowin         (fs_allowin),
        .fs_to_preif_offset (fs_to_preif_offset),
        .in_clear_all       (in_clear_all),
        .wr_line            (wr_line),
        .wr_pair_zero       (wr_pair_zero),
        .wr_pc              (wr_pc),
        .wr_count           (wr_count)
    );

    inst_queue u_queue (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .wr_line      (wr_line),
        .wr_pair_zero (wr_pair_zero),
        .wr_pc        (wr_pc),
        .wr_count     (wr_count),
        .line_data    (cache_rdata),
        .issue        (issue),
        .issue_two    (issue_two),
        .e0           (e0),
        .e1           (e1),
        .has_room     (has_room),
        .has_pair     (has_pair)
    );

    issue_pair u_pair (
        .e0                  (e0),
        .e1                  (e1),
        .has_pair            (has_pair),
        .flush               (flush),
        .issuing_state_clear (in_clear_all),
        .ds_allowin          (ds_allowin),
        .fs_to_ds_valid      (fs_to_ds_valid),
        .inst1               (inst1),
        .pc1                 (pc1),
        .inst2               (inst2),
        .pc2                 (pc2),
        .inst2_valid         (inst2_valid),
        .issue               (issue),
        .issue_two           (issue_two)
    );

endmodule

//--- tests/tb_fetch_stage.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module tb_fetch_stage;

    localparam int NUM_VEC     = 12;
    localparam int VEC_WORDS   = 11;
    localparam int CYCLE_LIMIT = 40 * NUM_VEC + 200;

    logic                           clk;
    logic                           reset;
    logic                           to_fs_valid;
    logic [`WORD_W-1:0]             fetch_pc;
    logic                           no_inst;
    logic                           cache_data_ok;
    logic [3:0]                     cache_data_num;
    logic [`LINE_WORDS*`WORD_W-1:0] cache_rdata;
    logic                           ds_allowin;
    logic                           flush;
    logic                           fs_allowin;
    logic [5:0]                     fs_to_preif_offset;
    logic                           fs_to_ds_valid;
    logic [31:0]                    inst1;
    logic [31:0]                    pc1;
    logic [31:0]                    inst2;
    logic [31:0]                    pc2;
    logic                           inst2_valid;

    logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];
    logic [31:0] q_inst [$];
    logic [31:0] q_pc [$];
    logic [31:0] lfsr;
    logic [1:0]  rand_delay;
    logic [1:0]  resp_delay;
    logic        pend_push;
    logic        pend_zero;
    logic [31:0] pend_pc;
    int          pend_n;
    logic [31:0] pend_words [8];
    logic [5:0]  exp_offset;
    logic        fetch_busy;
    logic        busy_no_inst;
    logic        was_stalled;
    logic [31:0] prev_inst1;
    logic [31:0] prev_pc1;
    logic [31:0] prev_inst2;
    logic [31:0] prev_pc2;
    logic        prev_inst2_valid;
    int          error_count;
    int          check_count;
    int          cycle_count;

    fetch_stage uut (
        .clk                (clk),
        .reset              (reset),
        .to_fs_valid        (to_fs_valid),
        .fetch_pc           (fetch_pc),
        .no_inst            (no_inst),
        .cache_data_ok      (cache_data_ok),
        .cache_data_num     (cache_data_num),
        .cache_rdata        (cache_rdata),
        .ds_allowin         (ds_allowin),
        .flush              (flush),
        .fs_allowin         (fs_allowin),
        .fs_to_preif_offset (fs_to_preif_offset),
        .fs_to_ds_valid     (fs_to_ds_valid),
        .inst1              (inst1),
        .pc1                (pc1),
        .inst2              (inst2),
        .pc2                (pc2),
        .inst2_valid        (inst2_valid)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic younger_is_branch(logic [31:0] i);
        logic [5:0] op;
        logic [4:0] rt;
        op = i[31:26];
        rt = i[20:16];
        if (op >= 6'h02 && op <= 6'h05) return 1'b1;
        if ((op == 6'h06 || op == 6'h07) && rt == 5'd0) return 1'b1;
        if (op == 6'h01 && (rt[3:1] == 3'b000)) return 1'b1;
        if (op == 6'h00 && i[5:0] == 6'h08 && i[20:6] == 15'd0) return 1'b1;
        return op == 6'h00 && i[5:0] == 6'h09 && rt == 5'd0 && i[10:6] == 5'd0;
    endfunction

    function automatic logic hilo_move(logic [31:0] i);
        return i[31:26] == 6'h00 && (i[5:0] == 6'h10 || i[5:0] == 6'h12)
            && i[25:16] == 10'd0 && i[10:6] == 5'd0;
    endfunction

    function automatic logic late_result(logic [31:0] i);
        if (i[31:26] >= 6'h20 && i[31:26] <= 6'h26) return 1'b1;
        if (i[31:26] == 6'h10) return i[25:21] == 5'd0 && i[10:3] == 8'd0;
        return hilo_move(i);
    endfunction

    function automatic logic uses_hilo_unit(logic [31:0] i);
        if (i[31:26] == 6'h1c) return i[5:0] == 6'h02 && i[10:6] == 5'd0;
        return i[31:26] == 6'h00 && i[5:2] == 4'b0110 && i[15:6] == 10'd0;
    endfunction

    // expected hold-back of the younger word
    function automatic logic pair_blocked(logic [31:0] a, logic [31:0] b);
        logic [4:0] dst;
        logic       rs_used;
        logic       rt_used;
        logic [5:0] op;
        op      = b[31:26];
        dst     = hilo_move(a) ? a[15:11] : a[20:16];
        rs_used = !(op == 6'h02 || op == 6'h03 || op == 6'h10);
        rt_used = op == 6'h00 || op == 6'h1c || op == 6'h04 || op == 6'h05
            || op == 6'h22 || op == 6'h26 || op[5:3] == 3'b101
            || (op == 6'h10 && b[25:21] == 5'd4);
        if (younger_is_branch(b)) return 1'b1;
        if (late_result(a) && dst != 5'd0
            && ((rs_used && b[25:21] == dst) || (rt_used && b[20:16] == dst))) return 1'b1;
        return uses_hilo_unit(a) && uses_hilo_unit(b);
    endfunction

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        error_count++;
        $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    // decode back-pressure and response delay picks
    always @(negedge clk) begin
        lfsr = lfsr_step(lfsr);
        rand_delay[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        rand_delay[1] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        ds_allowin <= lfsr[0];
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        logic hold;
        logic exp_valid;
        logic exp_allowin;
        if (!reset) begin
            check_count++;
            // one request in flight, and a whole line must still fit
            exp_allowin = !fetch_busy && q_inst.size() <= 7;
            assert (fs_allowin == exp_allowin) else
                report_mismatch("fs_allowin", 32'(fs_allowin), 32'(exp_allowin));
            assert (fs_to_preif_offset == exp_offset) else
                report_mismatch("offset", 32'(fs_to_preif_offset), 32'(exp_offset));
            exp_valid = q_inst.size() >= 2 && !flush;
            assert (fs_to_ds_valid == exp_valid) else
                report_mismatch("fs_to_ds_valid", 32'(fs_to_ds_valid), 32'(exp_valid));
            if (was_stalled && fs_to_ds_valid) begin
                assert (inst1 == prev_inst1 && pc1 == prev_pc1 && inst2 == prev_inst2
                        && pc2 == prev_pc2 && inst2_valid == prev_inst2_valid) else
                    report_mismatch("outputs moved during stall", pc1, prev_pc1);
            end
            if (fs_to_ds_valid && ds_allowin && q_inst.size() >= 2) begin
                hold = pair_blocked(q_inst[0], q_inst[1]);
                assert (inst1 == q_inst[0]) else report_mismatch("inst1", inst1, q_inst[0]);
                assert (pc1 == q_pc[0]) else report_mismatch("pc1", pc1, q_pc[0]);
                assert (pc2 == q_pc[1]) else report_mismatch("pc2", pc2, q_pc[1]);
                assert (inst2_valid == !hold) else
                    report_mismatch("inst2_valid", 32'(inst2_valid), 32'(!hold));
                assert (inst2 == (hold ? 32'd0 : q_inst[1])) else
                    report_mismatch("inst2", inst2, hold ? 32'd0 : q_inst[1]);
                void'(q_inst.pop_front());
                void'(q_pc.pop_front());
                if (!hold) begin
                    void'(q_inst.pop_front());
                    void'(q_pc.pop_front());
                end
            end
            was_stalled      = fs_to_ds_valid && !ds_allowin;
            prev_inst1       = inst1;
            prev_pc1         = pc1;
            prev_inst2       = inst2;
            prev_pc2         = pc2;
            prev_inst2_valid = inst2_valid;
            if (fetch_busy) begin
                if (busy_no_inst || cache_data_ok) begin
                    fetch_busy = 1'b0;
                end
            end else if (to_fs_valid && exp_allowin) begin
                fetch_busy   = 1'b1;
                busy_no_inst = no_inst;
            end
            if (flush) begin
                q_inst.delete();
                q_pc.delete();
                exp_offset = 6'd4;
            end else if (pend_push) begin
                for (int k = 0; k < pend_n; k++) begin
                    q_inst.push_back(pend_zero ? 32'd0 : pend_words[k]);
                    q_pc.push_back(pend_pc + 32'(4 * k));
                end
                if (!pend_zero) exp_offset = 6'(4 * pend_n);
            end
        end
    end

    task automatic send_request(logic [31:0] pc, logic zero);
        logic taken;
        to_fs_valid = 1'b1;
        fetch_pc    = pc;
        no_inst     = zero;
        taken       = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = fs_allowin;
        end
        resp_delay = rand_delay;
        @(negedge clk);
        to_fs_valid = 1'b0;
        no_inst     = 1'b0;
    endtask

    task automatic return_line(int base, logic keep);
        int wait_cycles;
        wait_cycles = int'(resp_delay) % 3;
        repeat (wait_cycles) @(negedge clk);
        cache_data_ok  = 1'b1;
        cache_data_num = vec_mem[base+2][3:0];
        for (int k = 0; k < 8; k++) begin
            cache_rdata[k*32 +: 32] = vec_mem[base+3+k];
            pend_words[k]           = vec_mem[base+3+k];
        end
        pend_pc   = vec_mem[base+1];
        pend_n    = int'(vec_mem[base+2]);
        pend_zero = 1'b0;
        pend_push = keep;
        @(negedge clk);
        cache_data_ok = 1'b0;
        pend_push     = 1'b0;
    endtask

    initial begin
        int base;
        clk            = 1'b0;
        reset          = 1'b1;
        lfsr           = 32'h1c3ffc6e;
        rand_delay     = 2'd0;
        resp_delay     = 2'd0;
        to_fs_valid    = 1'b0;
        fetch_pc       = '0;
        no_inst        = 1'b0;
        flush          = 1'b0;
        cache_data_ok  = 1'b0;
        cache_data_num = 4'd0;
        cache_rdata    = '0;
        ds_allowin     = 1'b0;
        pend_push      = 1'b0;
        pend_zero      = 1'b0;
        pend_pc        = '0;
        pend_n         = 0;
        exp_offset     = 6'd4;
        fetch_busy     = 1'b0;
        busy_no_inst   = 1'b0;
        was_stalled    = 1'b0;
        error_count    = 0;
        check_count    = 0;
        cycle_count    = 0;
        $readmemh("tests/fetch_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int v = 0; v < NUM_VEC; v++) begin
            base = v * VEC_WORDS;
            case (vec_mem[base])
                32'd1: begin
                    send_request(vec_mem[base+1], 1'b1);
                    pend_pc   = vec_mem[base+1];
                    pend_n    = 2;
                    pend_zero = 1'b1;
                    pend_push = 1'b1;
                    @(negedge clk);
                    pend_push = 1'b0;
                end
                32'd2: begin
                    send_request(vec_mem[base+1], 1'b0);
                    flush = 1'b1;
                    @(negedge clk);
                    flush = 1'b0;
                    return_line(base, 1'b0);
                end
                default: begin
                    send_request(vec_mem[base+1], 1'b0);
                    return_line(base, 1'b1);
                end
            endcase
        end
        while (q_inst.size() >= 2) @(negedge clk);
        repeat (5) @(negedge clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- tests/fetch_vectors.txt
// flag (0 line, 1 no-inst, 2 flush) pc count then eight instruction words
// words past the count must never issue
00000000 00001000 00000008 00221821 8c240000 00822821 10220004 00000000 00220018 0064001a 24060001
00000000 00002000 00000005 08000010 00000000 8c240000 00822821 00220018 deadbeef deadbeef deadbeef
00000001 00003000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00004000 00000003 00003810 00e04021 24060001 deadbeef deadbeef deadbeef deadbeef deadbeef
00000002 00005000 00000008 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
00000000 00006000 00000008 8c200000 00000021 00220018 0064001a 08000010 00000000 24060001 00221821
00000000 00007000 00000001 24060001 deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef deadbeef
00000001 00008000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00009000 00000007 8c240000 00822821 00003810 00e04021 10220004 00220018 00220018 deadbeef
00000002 0000a000 00000004 99999999 aaaaaaaa bbbbbbbb cccccccc deadbeef deadbeef deadbeef deadbeef
00000000 0000b000 00000006 00221821 10220004 00000000 8c240000 00822821 24060001 deadbeef deadbeef
00000000 0000c000 00000008 00220018 0064001a 00003810 00e04021 08000010 00000000 8c240000 00822821

//--- build.f
+incdir+common
common/isa_pkg.sv
common/fetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/inst_queue.sv
verilog/issue_pair.sv
verilog/fetch_stage.sv
tests/tb_fetch_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
RTL_TOP   ?= fetch_stage
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
